/* Makefile */
TOP := exu_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -f vlog.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

/* hdl/exu.sv */
/*
 * execute stage top, dispatch feeding alu and branch unit
 */
`timescale 1ns/1ps

module exu #(
    parameter bit STATIC_PREDICT = 1'b1
) (
    input  logic                     clk,
    input  logic                     rst_i,
    input  exu_pkg::issue_t          issue_i,
    input  logic [exu_pkg::XLEN-1:0] old_pc_i,
    input  logic                     wb_ready_i,
    output exu_pkg::wb_t             wb_o,
    output logic                     stall_o,
    output logic                     jump_flag_o,
    output logic [exu_pkg::XLEN-1:0] jump_addr_o,
    output logic                     mispredict_o
);

    exu_pkg::alu_req_t alu_req;
    exu_pkg::bjp_req_t bjp_req;

    exu_dispatch u_exu_dispatch (
        .issue_i  (issue_i),
        .alu_req_o(alu_req),
        .bjp_req_o(bjp_req)
    );

    // writeback register stall is the stage stall
    exu_alu u_alu (
        .clk       (clk),
        .rst_i     (rst_i),
        .req_i     (alu_req),
        .wb_ready_i(wb_ready_i),
        .stall_o   (stall_o),
        .wb_o      (wb_o)
    );

    exu_bru #(
        .STATIC_PREDICT(STATIC_PREDICT)
    ) u_bru (
        .req_i       (bjp_req),
        .old_pc_i    (old_pc_i),
        .stall_i     (stall_o),
        .jump_flag_o (jump_flag_o),
        .jump_addr_o (jump_addr_o),
        .mispredict_o(mispredict_o)
    );

endmodule

/* hdl/exu_alu.sv */
/*
 * integer alu with one-entry writeback register
 * and back-pressure stall
 */
`timescale 1ns/1ps

module exu_alu (
    input  logic              clk,
    input  logic              rst_i,
    input  exu_pkg::alu_req_t req_i,
    input  logic              wb_ready_i,
    output logic              stall_o,
    output exu_pkg::wb_t      wb_o
);

    logic [exu_pkg::XLEN-1:0]        result;
    logic [4:0]                      shamt;
    logic                            load;
    logic                            we_q;
    logic [exu_pkg::REG_ADDR_W-1:0]  waddr_q;
    logic [exu_pkg::XLEN-1:0]        wdata_q;
    logic [exu_pkg::COMMIT_ID_W-1:0] commit_id_q;

    assign shamt = req_i.op2[4:0];

    always_comb begin
        case (req_i.op)
            exu_pkg::ALU_ADD:  result = req_i.op1 + req_i.op2;
            exu_pkg::ALU_SUB:  result = req_i.op1 - req_i.op2;
            exu_pkg::ALU_SLL:  result = req_i.op1 << shamt;
            exu_pkg::ALU_SLT:  result = {31'd0, $signed(req_i.op1) < $signed(req_i.op2)};
            exu_pkg::ALU_SLTU: result = {31'd0, req_i.op1 < req_i.op2};
            exu_pkg::ALU_XOR:  result = req_i.op1 ^ req_i.op2;
            exu_pkg::ALU_SRL:  result = req_i.op1 >> shamt;
            exu_pkg::ALU_SRA:  result = $unsigned($signed(req_i.op1) >>> shamt);
            exu_pkg::ALU_OR:   result = req_i.op1 | req_i.op2;
            exu_pkg::ALU_AND:  result = req_i.op1 & req_i.op2;
            default:           result = '0;
        endcase
    end

    // take a new result when empty or when the current one drains
    assign load    = req_i.valid && (!we_q || wb_ready_i);
    assign stall_o = req_i.valid && we_q && !wb_ready_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            we_q <= 1'b0;
        end else if (load) begin
            we_q <= 1'b1;
        end else if (wb_ready_i) begin
            we_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            waddr_q     <= req_i.rd;
            wdata_q     <= result;
            commit_id_q <= req_i.commit_id;
        end
    end

    always_comb begin
        wb_o.we        = we_q;
        wb_o.waddr     = waddr_q;
        wb_o.wdata     = wdata_q;
        wb_o.commit_id = commit_id_q;
    end

    // held entry must not change until writeback takes it
    a_wb_hold: assert property (@(posedge clk) disable iff (rst_i)
        (wb_o.we && !wb_ready_i) |=> $stable(wb_o))
        else $error("writeback entry changed while held");

    // a refused request leaves the held entry in place
    a_no_stall_empty: assert property (@(posedge clk) disable iff (rst_i)
        stall_o |=> wb_o.we)
        else $error("writeback register emptied while a request was stalled");

    a_we_known: assert property (@(posedge clk) !rst_i |-> !$isunknown(wb_o.we))
        else $error("writeback we unknown after reset");

endmodule

/* hdl/exu_bru.sv */
/*
 * branch compare, target adder, static prediction
 * and redirect decision
 */
`timescale 1ns/1ps

module exu_bru #(
    parameter bit STATIC_PREDICT = 1'b1
) (
    input  exu_pkg::bjp_req_t         req_i,
    input  logic [exu_pkg::XLEN-1:0]  old_pc_i,
    input  logic                      stall_i,
    output logic                      jump_flag_o,
    output logic [exu_pkg::XLEN-1:0]  jump_addr_o,
    output logic                      mispredict_o
);

    logic                     is_jal;
    logic                     is_jalr;
    logic                     is_branch;
    logic                     cmp_res;
    logic                     actual_taken;
    logic                     predicted;
    logic [exu_pkg::XLEN-1:0] target;

    assign is_jal    = req_i.valid && (req_i.op == exu_pkg::BJP_JAL);
    assign is_jalr   = req_i.valid && (req_i.op == exu_pkg::BJP_JALR);
    assign is_branch = req_i.valid && !req_i.op[3]
                       && (req_i.op != exu_pkg::BJP_JAL) && (req_i.op != exu_pkg::BJP_JALR);

    always_comb begin
        case (req_i.op)
            exu_pkg::BJP_BEQ:  cmp_res = (req_i.op1 == req_i.op2);
            exu_pkg::BJP_BNE:  cmp_res = (req_i.op1 != req_i.op2);
            exu_pkg::BJP_BLT:  cmp_res = ($signed(req_i.op1) < $signed(req_i.op2));
            exu_pkg::BJP_BLTU: cmp_res = (req_i.op1 < req_i.op2);
            exu_pkg::BJP_BGE:  cmp_res = ($signed(req_i.op1) >= $signed(req_i.op2));
            exu_pkg::BJP_BGEU: cmp_res = (req_i.op1 >= req_i.op2);
            default:           cmp_res = 1'b0;
        endcase
    end

    assign actual_taken = is_jal || is_jalr || (is_branch && cmp_res);

    // backward branches and jal predicted taken by fetch
    if (STATIC_PREDICT) begin : g_predict
        assign predicted = is_jal || (is_branch && req_i.offset[exu_pkg::XLEN-1]);
    end else begin : g_no_predict
        assign predicted = 1'b0;
    end

    assign mispredict_o = predicted && !actual_taken;

    // jalr target has bit 0 cleared
    always_comb begin
        target = req_i.base + req_i.offset;
        if (is_jalr) begin
            target[0] = 1'b0;
        end
    end

    assign jump_flag_o = !stall_i && ((actual_taken && !predicted) || mispredict_o);
    assign jump_addr_o = mispredict_o ? old_pc_i + exu_pkg::XLEN'(4) : target;

    // only a conditional branch can be predicted wrong
    always_comb begin
        a_mispredict_branch: assert final (!mispredict_o || (req_i.valid && (req_i.op inside {
            exu_pkg::BJP_BEQ, exu_pkg::BJP_BNE, exu_pkg::BJP_BLT,
            exu_pkg::BJP_BLTU, exu_pkg::BJP_BGE, exu_pkg::BJP_BGEU})))
            else $error("mispredict on a non-branch request");
    end

endmodule

/* hdl/exu_dispatch.sv */
/*
 * issue word decode, forms alu and branch requests
 */
`timescale 1ns/1ps

module exu_dispatch (
    input  exu_pkg::issue_t   issue_i,
    output exu_pkg::alu_req_t alu_req_o,
    output exu_pkg::bjp_req_t bjp_req_o
);

    logic [exu_pkg::COMMIT_ID_W-1:0] commit_id;
    logic                            is_jump;
    logic                            is_jalr;

    // instruction id zero-extended into the commit id
    assign commit_id = {{(exu_pkg::COMMIT_ID_W - exu_pkg::INST_ID_W){1'b0}}, issue_i.inst_id};

    assign is_jalr = (issue_i.dec.op.bjp == exu_pkg::BJP_JALR);
    assign is_jump = (issue_i.dec.op.bjp == exu_pkg::BJP_JAL) || is_jalr;

    always_comb begin
        alu_req_o = '0;
        bjp_req_o = '0;
        if (issue_i.valid) begin
            case (issue_i.dec.grp)
                exu_pkg::GRP_ALU: begin
                    alu_req_o.valid     = 1'b1;
                    alu_req_o.op        = issue_i.dec.op.alu;
                    alu_req_o.op1       = issue_i.rs1_data;
                    alu_req_o.op2       = issue_i.dec.use_imm ? issue_i.imm
                                                              : issue_i.rs2_data;
                    alu_req_o.rd        = issue_i.rd;
                    alu_req_o.commit_id = commit_id;
                end
                exu_pkg::GRP_BJP: begin
                    bjp_req_o.valid  = 1'b1;
                    bjp_req_o.op     = issue_i.dec.op.bjp;
                    bjp_req_o.op1    = issue_i.rs1_data;
                    bjp_req_o.op2    = issue_i.rs2_data;
                    // jalr is register relative, the rest pc relative
                    bjp_req_o.base   = is_jalr ? issue_i.rs1_data : issue_i.pc;
                    bjp_req_o.offset = issue_i.imm;
                    // link value pc + 4 goes through the alu
                    if (is_jump) begin
                        alu_req_o.valid     = 1'b1;
                        alu_req_o.op        = exu_pkg::ALU_ADD;
                        alu_req_o.op1       = issue_i.pc;
                        alu_req_o.op2       = exu_pkg::XLEN'(4);
                        alu_req_o.rd        = issue_i.rd;
                        alu_req_o.commit_id = commit_id;
                    end
                end
                default: begin
                    // group none, nothing dispatched
                end
            endcase
        end
    end

endmodule

/* hdl/exu_pkg.sv */
/*
 * shared widths, operation enums, decode word union
 * and the pipeline structs of the execute stage
 */
package exu_pkg;

    parameter int XLEN        = 32;
    parameter int REG_ADDR_W  = 5;
    parameter int INST_ID_W   = 2;
    parameter int COMMIT_ID_W = 4;

    // integer alu operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // branch and jump kinds, top bit always zero
    typedef enum logic [3:0] {
        BJP_BEQ,
        BJP_BNE,
        BJP_BLT,
        BJP_BLTU,
        BJP_BGE,
        BJP_BGEU,
        BJP_JAL,
        BJP_JALR
    } bjp_op_e;

    typedef enum logic [1:0] {
        GRP_NONE,
        GRP_ALU,
        GRP_BJP
    } dec_grp_e;

    // same op field, meaning picked by the group
    typedef union packed {
        alu_op_e alu;
        bjp_op_e bjp;
    } dec_op_u;

    typedef struct packed {
        logic     spare;
        dec_grp_e grp;
        logic     use_imm;
        dec_op_u  op;
    } dec_info_t;

    typedef struct packed {
        logic                  valid;
        dec_info_t             dec;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [REG_ADDR_W-1:0] rd;
        logic [INST_ID_W-1:0]  inst_id;
    } issue_t;

    typedef struct packed {
        logic                   valid;
        alu_op_e                op;
        logic [XLEN-1:0]        op1;
        logic [XLEN-1:0]        op2;
        logic [REG_ADDR_W-1:0]  rd;
        logic [COMMIT_ID_W-1:0] commit_id;
    } alu_req_t;

    // op1/op2 feed the compare, base/offset the target adder
    typedef struct packed {
        logic            valid;
        bjp_op_e         op;
        logic [XLEN-1:0] op1;
        logic [XLEN-1:0] op2;
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] offset;
    } bjp_req_t;

    typedef struct packed {
        logic                   we;
        logic [REG_ADDR_W-1:0]  waddr;
        logic [XLEN-1:0]        wdata;
        logic [COMMIT_ID_W-1:0] commit_id;
    } wb_t;

endpackage

/* tests/exu_tb.sv */
/*
 * directed testbench for the execute stage: alu ops, back-pressure,
 * branches, static prediction, jumps and stall gating
 */
`timescale 1ns/1ps

module exu_tb;

    localparam int REPS           = 4;
    localparam int RESET_CYCLES   = 5;
    localparam int PLANNED_CYCLES = RESET_CYCLES + 2 * 10 * 2 + 2 * 6 * REPS + 2 * 2 * REPS + 24;

    logic              clk;
    logic              rst;
    exu_pkg::issue_t   issue;
    logic [31:0]       old_pc;
    logic              wb_ready;
    exu_pkg::wb_t      wb;
    logic              stall;
    logic              jump_flag;
    logic [31:0]       jump_addr;
    logic              mispredict;
    logic [31:0]       rng_state;
    int                errors;
    int                checks;

    exu #(
        .STATIC_PREDICT(1'b1)
    ) dut_i (
        .clk         (clk),
        .rst_i       (rst),
        .issue_i     (issue),
        .old_pc_i    (old_pc),
        .wb_ready_i  (wb_ready),
        .wb_o        (wb),
        .stall_o     (stall),
        .jump_flag_o (jump_flag),
        .jump_addr_o (jump_addr),
        .mispredict_o(mispredict)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // signed compare done by flipping the sign bits
    function automatic logic lt_signed(input logic [31:0] a, input logic [31:0] b);
        return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    endfunction

    function automatic logic [31:0] alu_model(input logic [3:0] op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] fill;
        sh = b[4:0];
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
        case (exu_pkg::alu_op_e'(op))
            exu_pkg::ALU_ADD:  return a + b;
            exu_pkg::ALU_SUB:  return a + ~b + 32'd1;
            exu_pkg::ALU_SLL:  return a << sh;
            exu_pkg::ALU_SLT:  return {31'd0, lt_signed(a, b)};
            exu_pkg::ALU_SLTU: return {31'd0, a < b};
            exu_pkg::ALU_XOR:  return a ^ b;
            exu_pkg::ALU_SRL:  return a >> sh;
            exu_pkg::ALU_SRA:  return (a >> sh) | fill;
            exu_pkg::ALU_OR:   return a | b;
            default:           return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [3:0] op, input logic [31:0] a,
                                          input logic [31:0] b);
        case (exu_pkg::bjp_op_e'(op))
            exu_pkg::BJP_BEQ:  return a == b;
            exu_pkg::BJP_BNE:  return a != b;
            exu_pkg::BJP_BLT:  return lt_signed(a, b);
            exu_pkg::BJP_BLTU: return a < b;
            exu_pkg::BJP_BGE:  return !lt_signed(a, b);
            default:           return !(a < b);
        endcase
    endfunction

    function automatic exu_pkg::issue_t make_issue(
        input exu_pkg::dec_grp_e grp, input logic [3:0] op, input logic use_imm,
        input logic [31:0] imm, input logic [31:0] pc, input logic [31:0] rs1,
        input logic [31:0] rs2, input logic [4:0] rd, input logic [1:0] id);
        exu_pkg::issue_t t;
        t = '0;
        t.valid = 1'b1;
        t.dec.grp = grp;
        t.dec.use_imm = use_imm;
        if (grp == exu_pkg::GRP_ALU) begin
            t.dec.op.alu = exu_pkg::alu_op_e'(op);
        end else begin
            t.dec.op.bjp = exu_pkg::bjp_op_e'(op);
        end
        t.imm = imm;
        t.pc = pc;
        t.rs1_data = rs1;
        t.rs2_data = rs2;
        t.rd = rd;
        t.inst_id = id;
        return t;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // drive point, 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_wb(input logic [4:0] rd, input logic [1:0] id, input logic [31:0] data);
        check_value("wb_o.we", wb.we, 1);
        check_value("wb_o.waddr", wb.waddr, rd);
        check_value("wb_o.commit_id", wb.commit_id, {2'b00, id});
        check_value("wb_o.wdata", wb.wdata, data);
    endtask

    task automatic test_alu_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] r;
        for (int op = 0; op < 10; op++) begin
            for (int m = 0; m < 2; m++) begin
                a = rand_word();
                b = rand_word();
                imm = rand_word();
                r = rand_word();
                next_cycle();
                issue = make_issue(exu_pkg::GRP_ALU, 4'(op), m[0], imm, 32'h0, a, b,
                                   r[4:0], r[6:5]);
                next_cycle();
                issue = '0;
                #2;
                check_wb(r[4:0], r[6:5], alu_model(4'(op), a, m[0] ? imm : b));
            end
        end
    endtask

    task automatic test_back_pressure();
        logic [31:0] a;
        logic [31:0] b;
        a = rand_word();
        b = rand_word();
        next_cycle();
        wb_ready = 1'b0;
        issue = make_issue(exu_pkg::GRP_ALU, 4'(exu_pkg::ALU_XOR), 1'b0, 0, 0, a, b, 5'd3, 2'd1);
        next_cycle();
        issue = make_issue(exu_pkg::GRP_ALU, 4'(exu_pkg::ALU_SUB), 1'b0, 0, 0, a, b, 5'd9, 2'd2);
        #2;
        check_value("stall_o", stall, 1);
        check_wb(5'd3, 2'd1, a ^ b);
        // second op held by the source
        next_cycle();
        #2;
        check_value("stall_o", stall, 1);
        check_wb(5'd3, 2'd1, a ^ b);
        next_cycle();
        wb_ready = 1'b1;
        #2;
        check_value("stall_o", stall, 0);
        check_wb(5'd3, 2'd1, a ^ b);
        next_cycle();
        issue = '0;
        #2;
        check_wb(5'd9, 2'd2, a - b);
        next_cycle();
        #2;
        check_value("wb_o.we", wb.we, 0);
    endtask

    // backward selects a negative offset, so the branch is predicted taken
    task automatic test_branches(input logic backward);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] pc;
        logic [31:0] imm;
        logic        taken;
        for (int op = 0; op < 6; op++) begin
            for (int n = 0; n < REPS; n++) begin
                a = rand_word();
                r = rand_word();
                b = (r[1:0] == 2'b00) ? a : rand_word();
                pc = rand_word() & 32'hffff_fffc;
                imm = (rand_word() & 32'h0000_0ffe) | (backward ? 32'hffff_f000 : 32'h0);
                taken = branch_model(4'(op), a, b);
                next_cycle();
                old_pc = pc;
                issue = make_issue(exu_pkg::GRP_BJP, 4'(op), 1'b0, imm, pc, a, b, 5'd0, 2'd0);
                #2;
                if (!backward) begin
                    check_value("jump_flag_o", jump_flag, taken);
                    check_value("jump_addr_o", jump_addr, pc + imm);
                    check_value("mispredict_o", mispredict, 0);
                end else if (taken) begin
                    check_value("jump_flag_o", jump_flag, 0);
                    check_value("mispredict_o", mispredict, 0);
                end else begin
                    check_value("jump_flag_o", jump_flag, 1);
                    check_value("mispredict_o", mispredict, 1);
                    check_value("jump_addr_o", jump_addr, pc + 32'd4);
                end
            end
        end
        next_cycle();
        issue = '0;
    endtask

    task automatic test_jumps();
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] imm;
        logic [31:0] r;
        for (int n = 0; n < REPS; n++) begin
            pc = rand_word() & 32'hffff_fffc;
            imm = rand_word();
            rs1 = rand_word();
            r = rand_word();
            next_cycle();
            old_pc = pc;
            issue = make_issue(exu_pkg::GRP_BJP, 4'(exu_pkg::BJP_JAL), 1'b0, imm, pc, rs1, 0,
                               r[4:0], r[6:5]);
            #2;
            check_value("jump_flag_o", jump_flag, 0);
            check_value("mispredict_o", mispredict, 0);
            next_cycle();
            issue = make_issue(exu_pkg::GRP_BJP, 4'(exu_pkg::BJP_JALR), 1'b0, imm, pc, rs1, 0,
                               r[9:5], r[11:10]);
            #2;
            check_wb(r[4:0], r[6:5], pc + 32'd4);
            check_value("jump_flag_o", jump_flag, 1);
            check_value("jump_addr_o", jump_addr, (rs1 + imm) & 32'hffff_fffe);
            check_value("mispredict_o", mispredict, 0);
            next_cycle();
            issue = '0;
            #2;
            check_wb(r[9:5], r[11:10], pc + 32'd4);
        end
    endtask

    task automatic test_stall_blocks_jump();
        logic [31:0] rs1;
        rs1 = rand_word();
        next_cycle();
        wb_ready = 1'b0;
        issue = make_issue(exu_pkg::GRP_ALU, 4'(exu_pkg::ALU_OR), 1'b1, 32'h55, 0, rs1, 0,
                           5'd7, 2'd3);
        next_cycle();
        issue = make_issue(exu_pkg::GRP_BJP, 4'(exu_pkg::BJP_JALR), 1'b0, 32'h40, 32'h100,
                           rs1, 0, 5'd1, 2'd0);
        #2;
        check_value("stall_o", stall, 1);
        check_value("jump_flag_o", jump_flag, 0);
        next_cycle();
        wb_ready = 1'b1;
        #2;
        check_value("stall_o", stall, 0);
        check_value("jump_flag_o", jump_flag, 1);
        check_wb(5'd7, 2'd3, rs1 | 32'h55);
        next_cycle();
        issue = '0;
        #2;
        check_wb(5'd1, 2'd0, 32'h104);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        issue = '0;
        old_pc = '0;
        wb_ready = 1'b1;
        rng_state = 32'hb19f;
        errors = 0;
        checks = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        #2;
        check_value("wb_o.we", wb.we, 0);
        check_value("stall_o", stall, 0);
        test_alu_ops();
        test_back_pressure();
        test_branches(1'b0);
        test_branches(1'b1);
        test_jumps();
        test_stall_blocks_jump();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog sized from the planned cycle count
    initial begin
        #(PLANNED_CYCLES * 4 + 200);
        $display("timeout: tests did not complete in time");
        $display("test failed");
        $finish;
    end

endmodule

/* vlog.f */
hdl/exu_pkg.sv
hdl/exu_dispatch.sv
hdl/exu_alu.sv
hdl/exu_bru.sv
hdl/exu.sv
tests/exu_tb.sv
